// ==== armCtrlPkg.sv ====
package armCtrlPkg;

  // ========================================
  // Instruction fields
  // ========================================
  localparam logic [1:0] OpDataProc  = 2'b00; // Class in bits 27..26
  localparam logic [1:0] OpLoadStore = 2'b01;
  localparam logic [1:0] OpBranch    = 2'b10;

  localparam logic [3:0] RegPc = 4'd15; // R15

  // Immediate formats for the extend unit
  localparam logic [1:0] ImmSrcDp     = 2'b00; // 8-bit rotated
  localparam logic [1:0] ImmSrcMem    = 2'b01; // 12-bit offset
  localparam logic [1:0] ImmSrcBranch = 2'b10; // 24-bit word offset

  // ========================================
  // Encodings
  // ========================================
  typedef enum logic [3:0] {
    aluAnd = 4'h0, aluEor = 4'h1, aluSub = 4'h2, aluRsb = 4'h3,
    aluAdd = 4'h4, aluAdc = 4'h5, aluSbc = 4'h6, aluRsc = 4'h7,
    aluTst = 4'h8, aluTeq = 4'h9, aluCmp = 4'hA, aluCmn = 4'hB,
    aluOrr = 4'hC, aluMov = 4'hD, aluBic = 4'hE, aluMvn = 4'hF
  } aluOpT;

  // Condition field, bits 31..28
  typedef enum logic [3:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'hA, condLt = 4'hB,
    condGt = 4'hC, condLe = 4'hD, condAl = 4'hE
  } condT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // ========================================
  // Stage control bundles
  // ========================================
  typedef struct packed {
    logic  aluSrc;     // Immediate as operand B
    aluOpT aluControl;
    logic  flagWrite;  // S bit
    logic  branch;
    logic  memWrite;
    logic  memtoReg;
    logic  regWrite;
    logic  pcSrc;      // Writes the PC
    logic  byteAccess;
    condT  cond;
  } exCtrlT;

  // Already gated by the condition check
  typedef struct packed {
    logic  memWrite;
    logic  memtoReg;
    logic  regWrite;
    logic  pcSrc;
    logic  byteAccess;
    logic  setFlags;
    flagsT flagsNext;
  } memCtrlT;

  typedef struct packed {
    logic  memtoReg;
    logic  regWrite;
    logic  pcSrc;
    logic  byteAccess;
    logic  setFlags;
    flagsT flagsNext;
  } wbCtrlT;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/100ps

module instrDecoder (
  input  logic [31:0]        InstrD,
  output armCtrlPkg::exCtrlT DecCtrl,
  output logic [1:0]         RegSrcD,
  output logic [1:0]         ImmSrcD
);

  logic undefD; // Register offset with bit 4 set

  assign undefD = (InstrD[27:25] == 3'b011) && InstrD[4];

  // ========================================
  // Main decoder and ALU control
  // ========================================
  always_comb begin
    DecCtrl            = '0;                    // No action unless a class matches
    DecCtrl.aluControl = armCtrlPkg::aluAdd;    // Non-DP default
    RegSrcD            = 2'b00;
    ImmSrcD            = armCtrlPkg::ImmSrcDp;

    case (InstrD[27:26])
      armCtrlPkg::OpDataProc: begin
        DecCtrl.aluSrc     = InstrD[25];                            // I bit
        DecCtrl.aluControl = armCtrlPkg::aluOpT'(InstrD[24:21]);    // Opcode passes through
        DecCtrl.flagWrite  = InstrD[20];                            // S bit
        // TST, TEQ, CMP and CMN only produce flags
        DecCtrl.regWrite   = (InstrD[24:23] != 2'b10);
      end

      armCtrlPkg::OpLoadStore: begin
        if (!undefD) begin
          RegSrcD            = {~InstrD[20], 1'b0};   // Store data read from Rd
          ImmSrcD            = armCtrlPkg::ImmSrcMem;
          DecCtrl.aluSrc     = ~InstrD[25];           // Bit 25 low means immediate offset
          // U bit picks offset direction
          DecCtrl.aluControl = InstrD[23] ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub;
          DecCtrl.memWrite   = ~InstrD[20];           // STR
          DecCtrl.memtoReg   = InstrD[20];            // LDR
          DecCtrl.regWrite   = InstrD[20];
          DecCtrl.byteAccess = InstrD[22];            // B bit
        end
      end

      armCtrlPkg::OpBranch: begin
        RegSrcD        = 2'b01;                       // PC as operand A
        ImmSrcD        = armCtrlPkg::ImmSrcBranch;
        DecCtrl.aluSrc = 1'b1;
        DecCtrl.branch = 1'b1;
      end

      default: begin
        // Coprocessor and SWI space decodes to a bubble
      end
    endcase

    // Branches and any write to R15 redirect fetch
    DecCtrl.pcSrc = DecCtrl.branch
                  | (DecCtrl.regWrite & (InstrD[15:12] == armCtrlPkg::RegPc));
    DecCtrl.cond  = armCtrlPkg::condT'(InstrD[31:28]);
  end

endmodule

// ==== ctrlPipeReg.sv ====
`timescale 1ns/100ps

module ctrlPipeReg #(
  parameter type PayloadT = logic
) (
  input  logic    clk,
  input  logic    rst,
  input  logic    en,   // Low holds the stage
  input  logic    clr,  // Flush, wins over en
  input  PayloadT d,
  output PayloadT q
);

  // Zero payload is a bubble since every control bit is active high
  always_ff @(posedge clk) begin
    if (rst || clr) begin
      q <= '0;
    end else if (en) begin
      q <= d;
    end
  end

endmodule

// ==== condUnit.sv ====
`timescale 1ns/100ps

module condUnit (
  input  armCtrlPkg::exCtrlT  ExCtrlE,
  input  armCtrlPkg::flagsT   FlagsE,     // Forwarded flags
  input  armCtrlPkg::flagsT   ALUFlagsE,
  output armCtrlPkg::memCtrlT MemCtrlE,
  output logic                BranchTakenE
);

  logic condExE;   // Condition passed
  logic setFlagsE;

  // ========================================
  // Condition table
  // ========================================
  always_comb begin
    case (ExCtrlE.cond)
      armCtrlPkg::condEq: condExE = FlagsE.z;
      armCtrlPkg::condNe: condExE = ~FlagsE.z;
      armCtrlPkg::condCs: condExE = FlagsE.c;
      armCtrlPkg::condCc: condExE = ~FlagsE.c;
      armCtrlPkg::condMi: condExE = FlagsE.n;
      armCtrlPkg::condPl: condExE = ~FlagsE.n;
      armCtrlPkg::condVs: condExE = FlagsE.v;
      armCtrlPkg::condVc: condExE = ~FlagsE.v;
      armCtrlPkg::condHi: condExE = FlagsE.c & ~FlagsE.z;         // Unsigned higher
      armCtrlPkg::condLs: condExE = ~FlagsE.c | FlagsE.z;
      armCtrlPkg::condGe: condExE = (FlagsE.n == FlagsE.v);
      armCtrlPkg::condLt: condExE = (FlagsE.n != FlagsE.v);
      armCtrlPkg::condGt: condExE = ~FlagsE.z & (FlagsE.n == FlagsE.v);
      armCtrlPkg::condLe: condExE = FlagsE.z | (FlagsE.n != FlagsE.v);
      armCtrlPkg::condAl: condExE = 1'b1;
      default:            condExE = 1'b0; // NV, never executes
    endcase
  end

  assign BranchTakenE = ExCtrlE.branch & condExE;
  assign setFlagsE    = ExCtrlE.flagWrite & condExE;

  // ========================================
  // Gated controls into Memory
  // ========================================
  always_comb begin
    MemCtrlE.memWrite   = ExCtrlE.memWrite & condExE;
    MemCtrlE.memtoReg   = ExCtrlE.memtoReg;          // Harmless without regWrite
    MemCtrlE.regWrite   = ExCtrlE.regWrite & condExE;
    MemCtrlE.pcSrc      = ExCtrlE.pcSrc & condExE;
    MemCtrlE.byteAccess = ExCtrlE.byteAccess;
    MemCtrlE.setFlags   = setFlagsE;
    // Failing instructions carry the current flags forward
    MemCtrlE.flagsNext  = setFlagsE ? ALUFlagsE : FlagsE;
  end

endmodule

// ==== flagFile.sv ====
`timescale 1ns/100ps

module flagFile (
  input  logic                clk,
  input  logic                rst,
  input  logic                StallW,
  input  armCtrlPkg::memCtrlT MemCtrlM,
  input  armCtrlPkg::wbCtrlT  WbCtrlW,
  output armCtrlPkg::flagsT   FlagsE
);

  armCtrlPkg::flagsT flagsQ; // Architectural NZCV

  // Commit in Writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsQ <= '0;
    end else if (WbCtrlW.setFlags && !StallW) begin
      flagsQ <= WbCtrlW.flagsNext;
    end
  end

  // Youngest pending update wins
  always_comb begin
    if (MemCtrlM.setFlags) begin
      FlagsE = MemCtrlM.flagsNext;  // One ahead in Memory
    end else if (WbCtrlW.setFlags) begin
      FlagsE = WbCtrlW.flagsNext;   // Not yet committed
    end else begin
      FlagsE = flagsQ;
    end
  end

endmodule

// ==== armController.sv ====
`timescale 1ns/100ps

module armController (
  input  logic               clk,
  input  logic               rst,
  // Decode
  input  logic [31:0]        InstrD,
  output logic [1:0]         RegSrcD,
  output logic [1:0]         ImmSrcD,
  // Execute
  input  armCtrlPkg::flagsT  ALUFlagsE,
  output armCtrlPkg::exCtrlT ExCtrlE,
  output logic               BranchTakenE,
  output armCtrlPkg::flagsT  FlagsE,
  // Memory
  output logic               MemWriteM,
  output logic               MemtoRegM,
  // Writeback
  output logic               RegWriteW,
  output logic               MemtoRegW,
  output logic               PCSrcW,
  // Hazard unit
  input  logic               StallE,
  input  logic               FlushE,
  input  logic               StallM,
  input  logic               StallW,
  input  logic               FlushW,
  output logic               PCWrPendingF
);

  armCtrlPkg::exCtrlT  decCtrlD;
  armCtrlPkg::memCtrlT memCtrlE;
  armCtrlPkg::memCtrlT memCtrlM;
  armCtrlPkg::wbCtrlT  wbCtrlM;  // Memory bundle minus memWrite
  armCtrlPkg::wbCtrlT  wbCtrlW;

  // ========================================
  // Decode
  // ========================================
  instrDecoder uDecoder (
    .InstrD  (InstrD),
    .DecCtrl (decCtrlD),
    .RegSrcD (RegSrcD),
    .ImmSrcD (ImmSrcD)
  );

  ctrlPipeReg #(.PayloadT(armCtrlPkg::exCtrlT)) regE (
    .clk (clk), .rst (rst), .en (~StallE), .clr (FlushE),
    .d   (decCtrlD),
    .q   (ExCtrlE)
  );

  // ========================================
  // Execute
  // ========================================
  condUnit uCond (
    .ExCtrlE      (ExCtrlE),
    .FlagsE       (FlagsE),
    .ALUFlagsE    (ALUFlagsE),
    .MemCtrlE     (memCtrlE),
    .BranchTakenE (BranchTakenE)
  );

  // Memory stage never flushes
  ctrlPipeReg #(.PayloadT(armCtrlPkg::memCtrlT)) regM (
    .clk (clk), .rst (rst), .en (~StallM), .clr (1'b0),
    .d   (memCtrlE),
    .q   (memCtrlM)
  );

  // ========================================
  // Memory and Writeback
  // ========================================
  assign MemWriteM = memCtrlM.memWrite;
  assign MemtoRegM = memCtrlM.memtoReg;

  assign wbCtrlM = '{
    memtoReg:   memCtrlM.memtoReg,
    regWrite:   memCtrlM.regWrite,
    pcSrc:      memCtrlM.pcSrc,
    byteAccess: memCtrlM.byteAccess,
    setFlags:   memCtrlM.setFlags,
    flagsNext:  memCtrlM.flagsNext
  };

  ctrlPipeReg #(.PayloadT(armCtrlPkg::wbCtrlT)) regW (
    .clk (clk), .rst (rst), .en (~StallW), .clr (FlushW),
    .d   (wbCtrlM),
    .q   (wbCtrlW)
  );

  flagFile uFlags (
    .clk      (clk),
    .rst      (rst),
    .StallW   (StallW),
    .MemCtrlM (memCtrlM),
    .WbCtrlW  (wbCtrlW),
    .FlagsE   (FlagsE)
  );

  assign RegWriteW = wbCtrlW.regWrite;
  assign MemtoRegW = wbCtrlW.memtoReg;
  assign PCSrcW    = wbCtrlW.pcSrc;

  // Fetch waits while any older PC write is in flight
  assign PCWrPendingF = decCtrlD.pcSrc | ExCtrlE.pcSrc | memCtrlM.pcSrc;

endmodule

// ==== tbCtrlModel.svh ====
// ========================================
// Reference model of the control pipeline
// ========================================
armCtrlPkg::exCtrlT  mE     = '0; // Execute register
armCtrlPkg::memCtrlT mM     = '0; // Memory register
armCtrlPkg::wbCtrlT  mW     = '0; // Writeback register
armCtrlPkg::flagsT   mFlags = '0; // Committed NZCV

// ARM condition table
function automatic logic condPass(input logic [3:0] cond, input armCtrlPkg::flagsT f);
  case (cond)
    4'h0: return f.z;
    4'h1: return !f.z;
    4'h2: return f.c;
    4'h3: return !f.c;
    4'h4: return f.n;
    4'h5: return !f.n;
    4'h6: return f.v;
    4'h7: return !f.v;
    4'h8: return f.c && !f.z;
    4'h9: return !f.c || f.z;
    4'hA: return f.n == f.v;
    4'hB: return f.n != f.v;
    4'hC: return !f.z && (f.n == f.v);
    4'hD: return f.z || (f.n != f.v);
    4'hE: return 1'b1;
    default: return 1'b0; // NV
  endcase
endfunction

// Flags seen by Execute, youngest pending first
function automatic armCtrlPkg::flagsT fwdFlags();
  if (mM.setFlags) return mM.flagsNext;
  if (mW.setFlags) return mW.flagsNext;
  return mFlags;
endfunction

task automatic decodeModel(input logic [31:0] ins, output armCtrlPkg::exCtrlT c,
                           output logic [1:0] regSrc, output logic [1:0] immSrc);
  c            = '0;
  c.aluControl = armCtrlPkg::aluAdd;
  c.cond       = armCtrlPkg::condT'(ins[31:28]);
  regSrc       = 2'b00;
  immSrc       = armCtrlPkg::ImmSrcDp;
  if (ins[27:26] == armCtrlPkg::OpDataProc) begin
    c.aluSrc     = ins[25];
    c.aluControl = armCtrlPkg::aluOpT'(ins[24:21]);
    c.flagWrite  = ins[20];
    c.regWrite   = (ins[24:21] < 4'h8) || (ins[24:21] > 4'hB); // Not TST..CMN
  end else if (ins[27:26] == armCtrlPkg::OpLoadStore && !(ins[25] && ins[4])) begin
    regSrc       = {!ins[20], 1'b0};
    immSrc       = armCtrlPkg::ImmSrcMem;
    c.aluSrc     = !ins[25];
    c.aluControl = ins[23] ? armCtrlPkg::aluAdd : armCtrlPkg::aluSub; // U bit
    c.memWrite   = !ins[20];
    c.memtoReg   = ins[20];
    c.regWrite   = ins[20];
    c.byteAccess = ins[22];
  end else if (ins[27:26] == armCtrlPkg::OpBranch) begin
    regSrc   = 2'b01;
    immSrc   = armCtrlPkg::ImmSrcBranch;
    c.aluSrc = 1'b1;
    c.branch = 1'b1;
  end
  c.pcSrc = c.branch || (c.regWrite && ins[15:12] == armCtrlPkg::RegPc);
endtask

// One rising edge of all three stage registers and the flag register
task automatic stepModel(input logic [31:0] ins, input armCtrlPkg::flagsT aluFlags,
                         input logic stallE, input logic flushE, input logic stallM,
                         input logic stallW, input logic flushW);
  armCtrlPkg::exCtrlT  dec;
  armCtrlPkg::memCtrlT mNext;
  armCtrlPkg::wbCtrlT  wNext;
  armCtrlPkg::flagsT   f;
  logic [1:0]          regSrc;
  logic [1:0]          immSrc;
  logic                pass;
  decodeModel(ins, dec, regSrc, immSrc);
  f    = fwdFlags();
  pass = condPass(mE.cond, f);
  mNext.memWrite   = mE.memWrite && pass;
  mNext.memtoReg   = mE.memtoReg;
  mNext.regWrite   = mE.regWrite && pass;
  mNext.pcSrc      = mE.pcSrc && pass;
  mNext.byteAccess = mE.byteAccess;
  mNext.setFlags   = mE.flagWrite && pass;
  mNext.flagsNext  = mNext.setFlags ? aluFlags : f; // Failing op keeps flags
  wNext = '{mM.memtoReg, mM.regWrite, mM.pcSrc, mM.byteAccess, mM.setFlags, mM.flagsNext};
  if (mW.setFlags && !stallW) mFlags = mW.flagsNext;
  if (flushW) mW = '0;
  else if (!stallW) mW = wNext;
  if (!stallM) mM = mNext;  // No flush in Memory
  if (flushE) mE = '0;
  else if (!stallE) mE = dec;
endtask

// ==== tbArmController.sv ====
`timescale 1ns/100ps

module tbArmController;

  localparam int ResetCycles   = 10;
  localparam int NumCycles     = 400;  // Random stimulus length
  localparam int TimeoutCycles = ResetCycles + NumCycles + 20;

  logic               clk;
  logic               rst;
  logic [31:0]        InstrD;
  armCtrlPkg::flagsT  ALUFlagsE;
  logic               StallE;
  logic               FlushE;
  logic               StallM;
  logic               StallW;
  logic               FlushW;
  logic [1:0]         RegSrcD;
  logic [1:0]         ImmSrcD;
  armCtrlPkg::exCtrlT ExCtrlE;
  logic               BranchTakenE;
  armCtrlPkg::flagsT  FlagsE;
  logic               MemWriteM;
  logic               MemtoRegM;
  logic               RegWriteW;
  logic               MemtoRegW;
  logic               PCSrcW;
  logic               PCWrPendingF;
  int                 seed;
  int                 cycleCount = 0;

  armController dut_i (
    .clk (clk), .rst (rst), .InstrD (InstrD), .RegSrcD (RegSrcD), .ImmSrcD (ImmSrcD),
    .ALUFlagsE (ALUFlagsE), .ExCtrlE (ExCtrlE), .BranchTakenE (BranchTakenE),
    .FlagsE (FlagsE), .MemWriteM (MemWriteM), .MemtoRegM (MemtoRegM),
    .RegWriteW (RegWriteW), .MemtoRegW (MemtoRegW), .PCSrcW (PCSrcW),
    .StallE (StallE), .FlushE (FlushE), .StallM (StallM), .StallW (StallW),
    .FlushW (FlushW), .PCWrPendingF (PCWrPendingF)
  );

  `include "tbCtrlModel.svh"

  task automatic reportFailure(input string line);
    $display("%s", line);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // ========================================
  // Compare tasks
  // ========================================
  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkBits2(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkExCtrl(input string name, input armCtrlPkg::exCtrlT got,
                             input armCtrlPkg::exCtrlT exp);
    if (got !== exp) reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkFlags(input string name, input armCtrlPkg::flagsT got,
                            input armCtrlPkg::flagsT exp);
    if (got !== exp) reportFailure($sformatf("FAILED %s: got 0x%h, expected 0x%h", name, got, exp));
  endtask

  task automatic checkOutputs();
    armCtrlPkg::exCtrlT dec;
    armCtrlPkg::flagsT  f;
    logic [1:0]         regSrc;
    logic [1:0]         immSrc;
    decodeModel(InstrD, dec, regSrc, immSrc);
    f = fwdFlags();
    checkBits2("RegSrcD", RegSrcD, regSrc);
    checkBits2("ImmSrcD", ImmSrcD, immSrc);
    checkExCtrl("ExCtrlE", ExCtrlE, mE);
    checkFlags("FlagsE", FlagsE, f);
    checkBit("BranchTakenE", BranchTakenE, mE.branch && condPass(mE.cond, f));
    checkBit("MemWriteM", MemWriteM, mM.memWrite);
    checkBit("MemtoRegM", MemtoRegM, mM.memtoReg);
    checkBit("RegWriteW", RegWriteW, mW.regWrite);
    checkBit("MemtoRegW", MemtoRegW, mW.memtoReg);
    checkBit("PCSrcW", PCSrcW, mW.pcSrc);
    checkBit("PCWrPendingF", PCWrPendingF, dec.pcSrc || mE.pcSrc || mM.pcSrc);
  endtask

  // ========================================
  // Stimulus
  // ========================================
  task automatic drawInstr(output logic [31:0] ins);
    logic [31:0] r;
    logic [31:0] f;
    logic [3:0]  rd;
    r  = $random(seed);
    f  = $random(seed);
    rd = (f[1:0] == 2'b00) ? armCtrlPkg::RegPc : f[5:2];  // R15 one time in four
    case (r[2:0])
      3'd0, 3'd1, 3'd2: ins = {r[31:28], 2'b00, f[6], f[10:7], f[11], f[15:12], rd, f[27:16]};
      3'd3, 3'd4: ins = {r[31:28], 2'b01, f[11:6], f[15:12], rd, f[27:21], 1'b0, f[19:16]};
      3'd5, 3'd6: ins = {r[31:28], 3'b101, f[6], r[27:4]};  // B or BL
      default:    ins = {r[31:28], 3'b011, r[27:8], 1'b1, r[7:4]};  // Undefined
    endcase
  endtask

  task automatic driveInputs();
    logic [31:0] r;
    drawInstr(InstrD);
    r         = $random(seed);
    ALUFlagsE = r[3:0];
    StallE    = (r[6:4] == 3'd0);
    StallM    = StallE || (r[10:7] == 4'd0);   // Hazard rule
    StallW    = StallE || (r[14:11] == 4'd0);
    FlushE    = (r[18:15] == 4'd0);
    FlushW    = (r[22:19] == 4'd0);
  endtask

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > TimeoutCycles) begin
      reportFailure($sformatf("Run did not finish within %0d cycles", TimeoutCycles));
    end
  end

  initial begin
    seed      = 32'hbaf21c39;
    rst       = 1'b1;
    InstrD    = '0;
    ALUFlagsE = '0;
    StallE    = 1'b0;
    FlushE    = 1'b0;
    StallM    = 1'b0;
    StallW    = 1'b0;
    FlushW    = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    checkOutputs();  // Empty pipeline
    for (int i = 0; i < NumCycles; i++) begin
      @(negedge clk);
      rst = 1'b0;
      driveInputs();
      @(posedge clk);
      stepModel(InstrD, ALUFlagsE, StallE, FlushE, StallM, StallW, FlushW);
      #1;
      checkOutputs();
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+.
armCtrlPkg.sv
instrDecoder.sv
ctrlPipeReg.sv
condUnit.sv
flagFile.sv
armController.sv
tbArmController.sv

// ==== Bender.yml ====
package:
  name: arm_controller

sources:
  - armCtrlPkg.sv
  - instrDecoder.sv
  - ctrlPipeReg.sv
  - condUnit.sv
  - flagFile.sv
  - armController.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tbArmController.sv
